// File: src/lidar_pkg.sv
package lidar_pkg;

  // Data widths
  localparam int RESULT_W = 16;
  localparam int BYTE_W   = 8;

  // One TDC measurement
  typedef logic [RESULT_W-1:0] sample_t;

  // TDC SPI opcodes
  typedef enum logic [BYTE_W-1:0] {
    OP_DUMMY       = 8'h00,
    OP_READ_RESULT = 8'hB0
  } tdc_opcode_e;

  // Channel controller states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FIRE,
    ST_WAIT_INT,
    ST_SPI_CMD,
    ST_SPI_HI,
    ST_SPI_LO,
    ST_PUSH
  } tdc_state_e;

  // Frame sequencer states
  typedef enum logic [1:0] {
    PK_SCAN,
    PK_HDR,
    PK_HI,
    PK_LO
  } pack_state_e;

  // Upper nibble of every frame header
  localparam logic [3:0] FRAME_SYNC = 4'hA;

  // Default build parameters, overridden from the top level
  localparam int DEF_N_CHANNELS = 2;
  localparam int DEF_SHOOT_DIV  = 2000;
  localparam int DEF_SPI_DIV    = 4;
  localparam int DEF_REF_DIV    = 8;
  localparam int DEF_BAUD_DIV   = 16;
  localparam int DEF_FIFO_DEPTH = 4;

endpackage

// File: src/ref_clk_divider.sv
`timescale 1ns/1ps

module ref_clk_divider import lidar_pkg::*; #(
  parameter int REF_DIV = DEF_REF_DIV
) (
  input  logic clk,
  input  logic rst_n,
  output logic ref_clk
);

  // Half period in system clocks
  localparam int HALF  = REF_DIV / 2;
  localparam int CNT_W = (HALF > 1) ? $clog2(HALF) : 1;

  logic [CNT_W-1:0] cnt;

  // Toggle every HALF cycles, giving clk / REF_DIV
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt     <= '0;
      ref_clk <= 1'b0;
    end else if (cnt == CNT_W'(HALF - 1)) begin
      cnt     <= '0;
      ref_clk <= ~ref_clk;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

// File: src/tdc_spi_master.sv
`timescale 1ns/1ps

module tdc_spi_master import lidar_pkg::*; #(
  parameter int SPI_DIV = DEF_SPI_DIV
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              xfer_start,
  input  logic [BYTE_W-1:0] xfer_byte,
  input  logic              hold_cs,
  input  logic              miso,
  output logic              busy,
  output logic [BYTE_W-1:0] rx_byte,
  output logic              mosi,
  output logic              sck,
  output logic              cs
);

  localparam int DIV_W = (SPI_DIV > 1) ? $clog2(SPI_DIV) : 1;
  // Two SCK edges per bit
  localparam int LAST_HALF = 2 * BYTE_W - 1;

  logic [DIV_W-1:0]  div_cnt;
  logic [3:0]        half_cnt;
  logic [BYTE_W-2:0] tx_shift;
  logic              hold_q;
  logic              load;
  logic              tick;
  logic              rise;
  logic              fall;
  logic              last;

  // Accept a byte only while idle
  assign load = xfer_start && !busy;
  // End of one SCK half period
  assign tick = busy && (div_cnt == DIV_W'(SPI_DIV - 1));
  // Mode 0, sample on rising SCK, shift on falling SCK
  assign rise = tick && !sck;
  assign fall = tick && sck;
  // Falling edge of bit 0 closes the byte
  assign last = fall && (half_cnt == 4'(LAST_HALF));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      sck      <= 1'b0;
      cs       <= 1'b1;
      mosi     <= 1'b0;
      hold_q   <= 1'b0;
      div_cnt  <= '0;
      half_cnt <= '0;
    end else if (load) begin
      busy     <= 1'b1;
      cs       <= 1'b0;
      hold_q   <= hold_cs;
      // MSB on the line before the first rising edge
      mosi     <= xfer_byte[BYTE_W-1];
      div_cnt  <= '0;
      half_cnt <= '0;
    end else if (tick) begin
      div_cnt  <= '0;
      half_cnt <= half_cnt + 1'b1;
      sck      <= ~sck;
      if (last) begin
        busy <= 1'b0;
        // Keep CS low between bytes of one transaction
        cs   <= ~hold_q;
      end else if (fall) begin
        mosi <= tx_shift[BYTE_W-2];
      end
    end else if (busy) begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // Shift registers, no reset needed
  always_ff @(posedge clk) begin
    // MSB goes straight to mosi, only the rest waits here
    if (load) begin
      tx_shift <= xfer_byte[BYTE_W-2:0];
    end else if (fall && !last) begin
      tx_shift <= {tx_shift[BYTE_W-3:0], 1'b0};
    end
    // Received byte stays valid once busy drops
    if (rise) begin
      rx_byte <= {rx_byte[BYTE_W-2:0], miso};
    end
  end

endmodule

// File: src/tdc_control.sv
`timescale 1ns/1ps

module tdc_control import lidar_pkg::*; #(
  parameter int SHOOT_DIV  = DEF_SHOOT_DIV,
  parameter int FIFO_DEPTH = DEF_FIFO_DEPTH
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              enable,
  input  logic              intb,
  input  logic              spi_busy,
  input  logic [BYTE_W-1:0] spi_rx_byte,
  input  logic              credit_return,
  output logic              start_signal,
  output logic              spi_start,
  output tdc_opcode_e       spi_byte,
  output logic              spi_hold_cs,
  output logic              push,
  output sample_t           push_data
);

  localparam int SHOT_W = (SHOOT_DIV > 1) ? $clog2(SHOOT_DIV) : 1;
  localparam int CRED_W = $clog2(FIFO_DEPTH + 1);

  tdc_state_e        state;
  logic [SHOT_W-1:0] shot_cnt;
  logic              shot;
  logic [CRED_W-1:0] credits;
  logic              busy_q;
  logic              spi_done;

  // Shot timer expiry, once every SHOOT_DIV cycles
  assign shot = (shot_cnt == SHOT_W'(SHOOT_DIV - 1));
  // Falling edge of SPI busy marks a finished byte
  assign spi_done = busy_q && !spi_busy;
  // Push lands the cycle after CS goes high
  assign push = (state == ST_PUSH);

  // Free running shot timer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      shot_cnt <= '0;
    end else if (shot) begin
      shot_cnt <= '0;
    end else begin
      shot_cnt <= shot_cnt + 1'b1;
    end
  end

  // Free FIFO slots, one spent per push
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credits <= CRED_W'(FIFO_DEPTH);
    end else if (push && !credit_return) begin
      credits <= credits - 1'b1;
    end else if (credit_return && !push) begin
      credits <= credits + 1'b1;
    end
  end

  // Shot, interrupt wait, three byte readout
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state        <= ST_IDLE;
      start_signal <= 1'b0;
      spi_start    <= 1'b0;
      spi_byte     <= OP_DUMMY;
      spi_hold_cs  <= 1'b0;
      busy_q       <= 1'b0;
    end else begin
      busy_q       <= spi_busy;
      start_signal <= 1'b0;
      spi_start    <= 1'b0;
      case (state)
        ST_IDLE: begin
          // Shot skipped when disabled or out of credits
          if (shot && enable && (credits != '0)) begin
            start_signal <= 1'b1;
            state        <= ST_FIRE;
          end
        end
        ST_FIRE: begin
          state <= ST_WAIT_INT;
        end
        ST_WAIT_INT: begin
          // Active low interrupt, measurement ready
          if (!intb) begin
            spi_start   <= 1'b1;
            spi_byte    <= OP_READ_RESULT;
            spi_hold_cs <= 1'b1;
            state       <= ST_SPI_CMD;
          end
        end
        ST_SPI_CMD: begin
          if (spi_done) begin
            spi_start   <= 1'b1;
            spi_byte    <= OP_DUMMY;
            spi_hold_cs <= 1'b1;
            state       <= ST_SPI_HI;
          end
        end
        ST_SPI_HI: begin
          // Last byte releases CS
          if (spi_done) begin
            spi_start   <= 1'b1;
            spi_byte    <= OP_DUMMY;
            spi_hold_cs <= 1'b0;
            state       <= ST_SPI_LO;
          end
        end
        ST_SPI_LO: begin
          if (spi_done) begin
            state <= ST_PUSH;
          end
        end
        ST_PUSH: begin
          state <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Result assembly, high byte first
  always_ff @(posedge clk) begin
    if ((state == ST_SPI_HI) && spi_done) begin
      push_data[RESULT_W-1:BYTE_W] <= spi_rx_byte;
    end
    if ((state == ST_SPI_LO) && spi_done) begin
      push_data[BYTE_W-1:0] <= spi_rx_byte;
    end
  end

endmodule

// File: src/sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo import lidar_pkg::*; #(
  parameter int FIFO_DEPTH = DEF_FIFO_DEPTH
) (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    push,
  input  sample_t push_data,
  input  logic    pop,
  output logic    not_empty,
  output sample_t head,
  output logic    credit_return
);

  localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CW = $clog2(FIFO_DEPTH + 1);

  sample_t       mem [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          do_pop;

  // No full flag, the writer never pushes without a credit
  assign do_pop    = pop && not_empty;
  assign not_empty = (count != '0);
  // First word fall through
  assign head      = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      // One credit back per entry removed
      credit_return <= do_pop;
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: src/serial_packer.sv
`timescale 1ns/1ps

module serial_packer import lidar_pkg::*; #(
  parameter int N_CHANNELS = DEF_N_CHANNELS
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [N_CHANNELS-1:0]   not_empty,
  input  sample_t [N_CHANNELS-1:0] head,
  input  logic                    tx_busy,
  output logic [N_CHANNELS-1:0]   pop,
  output logic                    tx_start,
  output logic [BYTE_W-1:0]       tx_byte
);

  localparam int CH_W  = (N_CHANNELS > 1) ? $clog2(N_CHANNELS) : 1;
  // Header low nibble holds the channel index
  localparam int IDX_W = BYTE_W - 4;

  pack_state_e     state;
  logic [CH_W-1:0] ch_ptr;
  sample_t         sample_q;
  logic            grab;

  // Current channel has data while scanning
  assign grab     = (state == PK_SCAN) && not_empty[ch_ptr];
  // One byte per UART idle slot
  assign tx_start = (state != PK_SCAN) && !tx_busy;

  always_comb begin
    pop         = '0;
    pop[ch_ptr] = grab;
  end

  always_comb begin
    case (state)
      PK_HDR:  tx_byte = {FRAME_SYNC, IDX_W'(ch_ptr)};
      PK_HI:   tx_byte = sample_q[RESULT_W-1:BYTE_W];
      PK_LO:   tx_byte = sample_q[BYTE_W-1:0];
      default: tx_byte = '0;
    endcase
  end

  // Head taken on the same edge that pops it
  always_ff @(posedge clk) begin
    if (grab) begin
      sample_q <= head[ch_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= PK_SCAN;
      ch_ptr <= '0;
    end else begin
      case (state)
        PK_SCAN: begin
          // Empty FIFOs skipped, one channel per cycle
          if (grab) begin
            state <= PK_HDR;
          end else begin
            ch_ptr <= (ch_ptr == CH_W'(N_CHANNELS - 1)) ? '0 : ch_ptr + 1'b1;
          end
        end
        PK_HDR: begin
          if (tx_start) begin
            state <= PK_HI;
          end
        end
        PK_HI: begin
          if (tx_start) begin
            state <= PK_LO;
          end
        end
        PK_LO: begin
          // Frame done, round robin moves on
          if (tx_start) begin
            state  <= PK_SCAN;
            ch_ptr <= (ch_ptr == CH_W'(N_CHANNELS - 1)) ? '0 : ch_ptr + 1'b1;
          end
        end
        default: begin
          state <= PK_SCAN;
        end
      endcase
    end
  end

endmodule

// File: src/uart_tx.sv
`timescale 1ns/1ps

module uart_tx import lidar_pkg::*; #(
  parameter int BAUD_DIV = DEF_BAUD_DIV
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              tx_start,
  input  logic [BYTE_W-1:0] tx_byte,
  output logic              tx_busy,
  output logic              serial_out
);

  localparam int BAUD_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;

  logic [BAUD_W-1:0] baud_cnt;
  logic [3:0]        bit_cnt;
  logic [BYTE_W-1:0] data_q;
  logic              load;
  logic              bit_end;

  assign load    = tx_start && !tx_busy;
  assign bit_end = tx_busy && (baud_cnt == BAUD_W'(BAUD_DIV - 1));

  always_ff @(posedge clk) begin
    if (load) begin
      data_q <= tx_byte;
    end
  end

  // 8N1, start bit then LSB first then stop bit
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tx_busy    <= 1'b0;
      serial_out <= 1'b1;
      baud_cnt   <= '0;
      bit_cnt    <= '0;
    end else if (load) begin
      tx_busy    <= 1'b1;
      serial_out <= 1'b0;
      baud_cnt   <= '0;
      bit_cnt    <= '0;
    end else if (bit_end) begin
      baud_cnt <= '0;
      bit_cnt  <= bit_cnt + 1'b1;
      if (bit_cnt == 4'd9) begin
        // Stop bit has run its full length
        tx_busy <= 1'b0;
      end else if (bit_cnt == 4'(BYTE_W)) begin
        serial_out <= 1'b1;
      end else begin
        serial_out <= data_q[bit_cnt[2:0]];
      end
    end else if (tx_busy) begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

endmodule

// File: src/lidar_top.sv
`timescale 1ns/1ps

module lidar_top import lidar_pkg::*; #(
  parameter int N_CHANNELS = DEF_N_CHANNELS,
  parameter int SHOOT_DIV  = DEF_SHOOT_DIV,
  parameter int SPI_DIV    = DEF_SPI_DIV,
  parameter int REF_DIV    = DEF_REF_DIV,
  parameter int BAUD_DIV   = DEF_BAUD_DIV,
  parameter int FIFO_DEPTH = DEF_FIFO_DEPTH
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [N_CHANNELS-1:0] channel_enable,
  input  logic [N_CHANNELS-1:0] tdc_intb,
  input  logic [N_CHANNELS-1:0] tdc_dout,
  output logic [N_CHANNELS-1:0] tdc_mosi,
  output logic [N_CHANNELS-1:0] tdc_sck,
  output logic [N_CHANNELS-1:0] tdc_cs,
  output logic [N_CHANNELS-1:0] tdc_ref_clk,
  output logic [N_CHANNELS-1:0] start_signal,
  output logic                  serial_out
);

  // FIFO side of the packer, one slot per channel
  logic [N_CHANNELS-1:0]    fifo_not_empty;
  sample_t [N_CHANNELS-1:0] fifo_head;
  logic [N_CHANNELS-1:0]    fifo_pop;
  // Packer to UART
  logic                     tx_start;
  logic [BYTE_W-1:0]        tx_byte;
  logic                     tx_busy;

  for (genvar ch = 0; ch < N_CHANNELS; ch++) begin : g_channel
    logic              spi_start;
    tdc_opcode_e       spi_byte;
    logic              spi_hold_cs;
    logic              spi_busy;
    logic [BYTE_W-1:0] spi_rx_byte;
    logic              push;
    sample_t           push_data;
    logic              credit_return;

    tdc_control #(.SHOOT_DIV(SHOOT_DIV), .FIFO_DEPTH(FIFO_DEPTH)) tdc_control_i (
      .clk(clk),
      .rst_n(rst_n),
      .enable(channel_enable[ch]),
      .intb(tdc_intb[ch]),
      .spi_busy(spi_busy),
      .spi_rx_byte(spi_rx_byte),
      .credit_return(credit_return),
      .start_signal(start_signal[ch]),
      .spi_start(spi_start),
      .spi_byte(spi_byte),
      .spi_hold_cs(spi_hold_cs),
      .push(push),
      .push_data(push_data)
    );

    tdc_spi_master #(.SPI_DIV(SPI_DIV)) tdc_spi_master_i (
      .clk(clk),
      .rst_n(rst_n),
      .xfer_start(spi_start),
      .xfer_byte(spi_byte),
      .hold_cs(spi_hold_cs),
      .miso(tdc_dout[ch]),
      .busy(spi_busy),
      .rx_byte(spi_rx_byte),
      .mosi(tdc_mosi[ch]),
      .sck(tdc_sck[ch]),
      .cs(tdc_cs[ch])
    );

    // Reference clock runs regardless of enable
    ref_clk_divider #(.REF_DIV(REF_DIV)) ref_clk_divider_i (
      .clk(clk),
      .rst_n(rst_n),
      .ref_clk(tdc_ref_clk[ch])
    );

    sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) sample_fifo_i (
      .clk(clk),
      .rst_n(rst_n),
      .push(push),
      .push_data(push_data),
      .pop(fifo_pop[ch]),
      .not_empty(fifo_not_empty[ch]),
      .head(fifo_head[ch]),
      .credit_return(credit_return)
    );
  end

  // Shared serial path
  serial_packer #(.N_CHANNELS(N_CHANNELS)) serial_packer_i (
    .clk(clk),
    .rst_n(rst_n),
    .not_empty(fifo_not_empty),
    .head(fifo_head),
    .tx_busy(tx_busy),
    .pop(fifo_pop),
    .tx_start(tx_start),
    .tx_byte(tx_byte)
  );

  uart_tx #(.BAUD_DIV(BAUD_DIV)) uart_tx_i (
    .clk(clk),
    .rst_n(rst_n),
    .tx_start(tx_start),
    .tx_byte(tx_byte),
    .tx_busy(tx_busy),
    .serial_out(serial_out)
  );

endmodule

// File: sim/tdc_model.sv
`timescale 1ns/1ps

module tdc_model import lidar_pkg::*; #(
  parameter int CH = 0
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start_signal,
  input  logic        sck,
  input  logic        cs,
  input  logic        mosi,
  output logic        intb,
  output logic        dout,
  output logic        busy,
  output logic        done,
  output logic [23:0] mosi_word,
  output logic [5:0]  sck_edges,
  output sample_t     result
);

  integer      seed;
  int unsigned delay;
  int unsigned shot_k;
  logic        counting;
  logic        sck_q;
  logic        cs_q;
  logic [23:0] miso_word;

  // Result for shot k of this channel
  function automatic sample_t shot_result(input int unsigned k);
    return sample_t'(CH * 4096 + k);
  endfunction

  initial begin
    seed = 32'h036f_5686;
    intb = 1'b1;
    dout = 1'b0;
    busy = 1'b0;
    done = 1'b0;
  end

  always @(posedge clk) begin
    sck_q <= sck;
    cs_q  <= cs;
    done  <= 1'b0;
    if (!rst_n) begin
      intb      <= 1'b1;
      dout      <= 1'b0;
      busy      <= 1'b0;
      counting  <= 1'b0;
      shot_k    <= 0;
      sck_edges <= '0;
    end else begin
      // Start pulse, measurement time is random
      if (start_signal) begin
        busy     <= 1'b1;
        counting <= 1'b1;
        delay    <= $unsigned($random(seed)) % 64;
      end else if (counting) begin
        if (delay == 0) begin
          intb     <= 1'b0;
          counting <= 1'b0;
        end else begin
          delay <= delay - 1;
        end
      end
      // CS low opens command byte plus 16 result bits
      if (cs_q && !cs) begin
        miso_word <= {8'h00, shot_result(shot_k)};
        dout      <= 1'b0;
        mosi_word <= '0;
        sck_edges <= '0;
      end
      // Mode 0, DUT samples on rising SCK
      if (!sck_q && sck) begin
        mosi_word <= {mosi_word[22:0], mosi};
        sck_edges <= sck_edges + 1'b1;
      end
      // Next bit after each falling SCK
      if (sck_q && !sck) begin
        miso_word <= {miso_word[22:0], 1'b0};
        dout      <= miso_word[22];
      end
      // Transaction over, release interrupt
      if (!cs_q && cs) begin
        intb   <= 1'b1;
        busy   <= 1'b0;
        done   <= 1'b1;
        result <= shot_result(shot_k);
        shot_k <= shot_k + 1;
      end
    end
  end

endmodule

// File: sim/tb_lidar_top.sv
`timescale 1ns/1ps

module tb_lidar_top import lidar_pkg::*; ();

  localparam int N_CH       = DEF_N_CHANNELS;
  localparam int SHOOT_DIV  = DEF_SHOOT_DIV;
  localparam int REF_DIV    = DEF_REF_DIV;
  localparam int BAUD_DIV   = DEF_BAUD_DIV;
  localparam int RX_TIMEOUT = 3 * SHOOT_DIV;
  localparam int MAX_DRAIN  = 16;

  logic            clk = 1'b0;
  logic            rst_n;
  logic [N_CH-1:0] channel_enable;
  wire  [N_CH-1:0] tdc_intb;
  wire  [N_CH-1:0] tdc_dout;
  wire  [N_CH-1:0] tdc_mosi;
  wire  [N_CH-1:0] tdc_sck;
  wire  [N_CH-1:0] tdc_cs;
  wire  [N_CH-1:0] tdc_ref_clk;
  wire  [N_CH-1:0] start_signal;
  wire             serial_out;

  // Model side bookkeeping
  wire  [N_CH-1:0] model_busy;
  wire  [N_CH-1:0] model_done;
  logic [23:0]     mosi_word [N_CH];
  logic [5:0]      sck_edges [N_CH];
  sample_t         model_result [N_CH];
  sample_t         exp_q [N_CH][$];
  int              start_count [N_CH] = '{default: 0};

  always #4 clk = ~clk;

  lidar_top lidar_top_i (
    .clk(clk),
    .rst_n(rst_n),
    .channel_enable(channel_enable),
    .tdc_intb(tdc_intb),
    .tdc_dout(tdc_dout),
    .tdc_mosi(tdc_mosi),
    .tdc_sck(tdc_sck),
    .tdc_cs(tdc_cs),
    .tdc_ref_clk(tdc_ref_clk),
    .start_signal(start_signal),
    .serial_out(serial_out)
  );

  for (genvar c = 0; c < N_CH; c++) begin : g_model
    tdc_model #(.CH(c)) tdc_model_i (
      .clk(clk),
      .rst_n(rst_n),
      .start_signal(start_signal[c]),
      .sck(tdc_sck[c]),
      .cs(tdc_cs[c]),
      .mosi(tdc_mosi[c]),
      .intb(tdc_intb[c]),
      .dout(tdc_dout[c]),
      .busy(model_busy[c]),
      .done(model_done[c]),
      .mosi_word(mosi_word[c]),
      .sck_edges(sck_edges[c]),
      .result(model_result[c])
    );
  end

  task automatic stop_run();
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic fail_with(input string what);
    $display("%0t ns: %s", $time, what);
    stop_run();
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns %s: got %b, expected %b", $time, name, actual, expected);
      stop_run();
    end
  endtask

  task automatic check_byte(input string name, input logic [BYTE_W-1:0] actual,
                            input logic [BYTE_W-1:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns %s: got 8'h%h, expected 8'h%h", $time, name, actual, expected);
      stop_run();
    end
  endtask

  task automatic check_sample(input string name, input sample_t actual, input sample_t expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns %s: got 16'h%h, expected 16'h%h", $time, name, actual, expected);
      stop_run();
    end
  endtask

  // SPI framing and opcode of every finished transaction
  always @(posedge clk) begin
    for (int c = 0; c < N_CH; c++) begin
      if (rst_n && start_signal[c]) begin
        start_count[c]++;
      end
      if (model_done[c]) begin
        check_byte($sformatf("tdc_mosi[%0d] opcode", c), mosi_word[c][23:16], OP_READ_RESULT);
        check_byte($sformatf("tdc_mosi[%0d] dummy hi", c), mosi_word[c][15:8], OP_DUMMY);
        check_byte($sformatf("tdc_mosi[%0d] dummy lo", c), mosi_word[c][7:0], OP_DUMMY);
        if (sck_edges[c] != 6'd24) begin
          fail_with($sformatf("tdc_cs[%0d] rose after %0d SCK edges instead of 24",
                              c, sck_edges[c]));
        end
        exp_q[c].push_back(model_result[c]);
      end
    end
  end

  // 8N1 receiver, samples mid-bit on falling clk
  task automatic receive_byte(output logic [BYTE_W-1:0] data);
    int waited;
    int i;
    waited = 0;
    @(negedge clk);
    while (serial_out !== 1'b0) begin
      if (waited == RX_TIMEOUT) begin
        fail_with("no UART start bit on serial_out within the timeout");
      end
      waited++;
      @(negedge clk);
    end
    repeat (BAUD_DIV / 2) @(negedge clk);
    check_bit("serial_out start bit", serial_out, 1'b0);
    for (i = 0; i < BYTE_W; i++) begin
      repeat (BAUD_DIV) @(negedge clk);
      data[i] = serial_out;
    end
    repeat (BAUD_DIV) @(negedge clk);
    check_bit("serial_out stop bit", serial_out, 1'b1);
  endtask

  // Header, high byte, low byte, checked against the model queue
  task automatic receive_frame(output logic [BYTE_W-1:0] hdr);
    logic [BYTE_W-1:0] hi;
    logic [BYTE_W-1:0] lo;
    sample_t           expected;
    int                ch;
    receive_byte(hdr);
    receive_byte(hi);
    receive_byte(lo);
    ch = int'(hdr[3:0]);
    check_byte("frame header sync", {hdr[7:4], 4'h0}, {FRAME_SYNC, 4'h0});
    if (ch >= N_CH) begin
      fail_with($sformatf("frame header names channel %0d, which does not exist", ch));
    end
    if (exp_q[ch].size() == 0) begin
      fail_with($sformatf("frame for channel %0d arrived with no TDC result behind it", ch));
    end
    expected = exp_q[ch].pop_front();
    check_sample($sformatf("frame sample of channel %0d", ch), {hi, lo}, expected);
  endtask

  task automatic reset_levels();
    int c;
    int i;
    channel_enable <= 'b1;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_bit("serial_out", serial_out, 1'b1);
    for (c = 0; c < N_CH; c++) begin
      check_bit($sformatf("tdc_cs[%0d]", c), tdc_cs[c], 1'b1);
      check_bit($sformatf("tdc_sck[%0d]", c), tdc_sck[c], 1'b0);
      check_bit($sformatf("tdc_mosi[%0d]", c), tdc_mosi[c], 1'b0);
      check_bit($sformatf("tdc_ref_clk[%0d]", c), tdc_ref_clk[c], 1'b0);
    end
    // First shot only after a full timer period
    for (i = 0; i < SHOOT_DIV - 1; i++) begin
      @(negedge clk);
      for (c = 0; c < N_CH; c++) begin
        check_bit($sformatf("start_signal[%0d]", c), start_signal[c], 1'b0);
        check_bit($sformatf("tdc_cs[%0d]", c), tdc_cs[c], 1'b1);
      end
      check_bit("serial_out", serial_out, 1'b1);
    end
  endtask

  task automatic ref_clock_rate();
    logic [N_CH-1:0] prev;
    int              rises [N_CH];
    int              c;
    @(negedge clk);
    prev = tdc_ref_clk;
    for (c = 0; c < N_CH; c++) begin
      rises[c] = 0;
    end
    repeat (10 * REF_DIV) begin
      @(negedge clk);
      for (c = 0; c < N_CH; c++) begin
        if (tdc_ref_clk[c] && !prev[c]) begin
          rises[c]++;
        end
      end
      prev = tdc_ref_clk;
    end
    for (c = 0; c < N_CH; c++) begin
      if (rises[c] < 9 || rises[c] > 11) begin
        fail_with($sformatf("tdc_ref_clk[%0d] showed %0d rising edges instead of 10",
                            c, rises[c]));
      end
    end
  endtask

  // Channel 0 alone, every header carries index 0
  task automatic single_channel();
    logic [BYTE_W-1:0] hdr;
    repeat (4) begin
      receive_frame(hdr);
      check_byte("frame header", hdr, {FRAME_SYNC, 4'h0});
    end
  endtask

  task automatic two_channels();
    logic [BYTE_W-1:0] hdr;
    int                seen [N_CH];
    int                c;
    for (c = 0; c < N_CH; c++) begin
      seen[c] = 0;
    end
    @(posedge clk);
    channel_enable <= '1;
    repeat (16) begin
      receive_frame(hdr);
      seen[hdr[3:0]]++;
    end
    for (c = 0; c < N_CH; c++) begin
      if (seen[c] == 0) begin
        fail_with($sformatf("no frame from channel %0d with all channels enabled", c));
      end
    end
  endtask

  task automatic disabled_channel();
    logic [BYTE_W-1:0] hdr;
    int                drained;
    int                base;
    @(posedge clk);
    channel_enable <= 2'b01;
    repeat (2) @(negedge clk);
    // Shot in flight and queued samples of channel 1 still come out
    drained = 0;
    while (model_busy[1] || exp_q[1].size() != 0) begin
      if (drained == MAX_DRAIN) begin
        fail_with("channel 1 kept producing samples after being disabled");
      end
      drained++;
      receive_frame(hdr);
    end
    base = start_count[1];
    repeat (6) begin
      receive_frame(hdr);
      check_byte("frame header", hdr, {FRAME_SYNC, 4'h0});
    end
    if (start_count[1] != base) begin
      fail_with("start_signal[1] pulsed while channel 1 was disabled");
    end
  endtask

  initial begin
    rst_n          = 1'b0;
    channel_enable = '0;
    reset_levels();
    ref_clock_rate();
    single_channel();
    two_channels();
    disabled_channel();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: sim.f
src/lidar_pkg.sv
src/ref_clk_divider.sv
src/tdc_spi_master.sv
src/tdc_control.sv
src/sample_fifo.sv
src/serial_packer.sv
src/uart_tx.sv
src/lidar_top.sv
sim/tdc_model.sv
sim/tb_lidar_top.sv
